//--- src/ser_pkg.sv
// serial transmitter package with the word control type, APB register map and status layout
`default_nettype none

package ser_pkg;

   // ##########################################################################
   // per-word transfer control
   // ##########################################################################

   // size sits in CTRL bits 7:0, bit order in bit 8
   typedef struct packed {
      logic       lsbfirst;   // 1 = low bits leave first
      logic [7:0] size;       // number of SW-wide beats per word
   } tx_ctrl_t;

   // ##########################################################################
   // APB register map
   // ##########################################################################

   localparam int ADDR_W = 4;

   // byte offsets
   localparam logic [ADDR_W-1:0] REG_CTRL   = 4'h0;
   localparam logic [ADDR_W-1:0] REG_DATA   = 4'h4;
   localparam logic [ADDR_W-1:0] REG_STATUS = 4'h8;

   // status word fields, fifo level in bits 15:8
   localparam int STAT_BUSY      = 0;
   localparam int STAT_FULL      = 1;
   localparam int STAT_LEVEL_LSB = 8;
   localparam int STAT_LEVEL_W   = 8;

endpackage

`default_nettype wire

//--- src/ser_word_if.sv
// ready/valid word channel between the transmitter blocks, with a fill level
`default_nettype none
`timescale 1ns/1ps

interface ser_word_if #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 4
);

   // level counts 0..DEPTH
   localparam int LW = $clog2(DEPTH + 1);

   // handshake, a word moves when both are high
   logic          valid;
   logic          ready;

   // word contents, held stable while valid waits for ready
   payload_t      payload;

   // occupancy reported back by the receiving side
   logic [LW-1:0] level;

   // sending side
   modport producer (output valid, output payload, input ready, input level);

   // receiving side
   modport consumer (input valid, input payload, output ready, output level);

endinterface

`default_nettype wire

//--- src/apb_tx_regs.sv
// APB slave with the transfer control register, data word pushes and status read-back
`default_nettype none
`timescale 1ns/1ps

module apb_tx_regs
   import ser_pkg::*;
#(
   parameter int PW = 32,
   parameter int SW = 2
) (
   input  wire              clk,
   input  wire              nreset,
   // apb slave
   input  wire [ADDR_W-1:0] paddr,
   input  wire              psel,
   input  wire              penable,
   input  wire              pwrite,
   input  wire [31:0]       pwdata,
   output logic [31:0]      prdata,
   output logic             pready,
   output logic             pslverr,
   // words towards the fifo
   ser_word_if.producer     word_in,
   // shifter activity
   input  wire              busy
);

   localparam int         CTRL_W    = $bits(tx_ctrl_t);
   localparam logic [7:0] MAX_BEATS = 8'(PW / SW);

   logic        access;
   logic        wr_ctrl;
   logic        wr_data;
   logic        rd_sel;
   tx_ctrl_t    ctrl_q;
   tx_ctrl_t    ctrl_new;
   logic        ctrl_bad;
   logic        fifo_full;
   logic [31:0] status;

   // ##########################################################################
   // access decode
   // ##########################################################################

   // zero-wait slave
   assign pready = 1'b1;

   // access phase
   assign access  = psel & penable;
   assign wr_ctrl = access & pwrite & (paddr == REG_CTRL);
   assign wr_data = access & pwrite & (paddr == REG_DATA);
   assign rd_sel  = psel & ~pwrite;

   // ##########################################################################
   // control register
   // ##########################################################################

   assign ctrl_new = tx_ctrl_t'(pwdata[CTRL_W-1:0]);

   // a word holds at most PW/SW beats, zero beats is meaningless
   assign ctrl_bad = (ctrl_new.size == 8'd0) | (ctrl_new.size > MAX_BEATS);

   // full-width words, msb first out of reset
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         ctrl_q.lsbfirst <= 1'b0;
         ctrl_q.size     <= MAX_BEATS;
      end else if (wr_ctrl && !ctrl_bad) begin
         ctrl_q <= ctrl_new;
      end
   end

   // ##########################################################################
   // data push
   // ##########################################################################

   // push offered during the access phase only
   assign word_in.valid   = wr_data;
   // each word carries the control in force at write time
   assign word_in.payload = {pwdata[PW-1:0], ctrl_q};

   // refused writes, the word is lost when the fifo cannot take it
   assign pslverr = (wr_data & ~word_in.ready) | (wr_ctrl & ctrl_bad);

   // ##########################################################################
   // read-back
   // ##########################################################################

   assign fifo_full = (word_in.level == word_in.DEPTH);

   always_comb begin
      status = '0;
      status[STAT_BUSY] = busy;
      status[STAT_FULL] = fifo_full;
      status[STAT_LEVEL_LSB +: STAT_LEVEL_W] = STAT_LEVEL_W'(word_in.level);
   end

   // data register reads back as zero
   always_comb begin
      prdata = '0;
      if (rd_sel) begin
         case (paddr)
            REG_CTRL:   prdata[CTRL_W-1:0] = ctrl_q;
            REG_STATUS: prdata = status;
            default:    prdata = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- src/tx_fifo.sv
// synchronous circular FIFO for any payload type, reporting its fill level
`default_nettype none
`timescale 1ns/1ps

module tx_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 4
) (
   input  wire          clk,
   input  wire          nreset,
   // write side, level goes back to the producer
   ser_word_if.consumer wr,
   // read side, head shown combinationally
   ser_word_if.producer rd
);

   localparam int AW = $clog2(DEPTH);
   localparam int LW = $clog2(DEPTH + 1);

   payload_t      mem [DEPTH];
   logic [AW-1:0] wptr;
   logic [AW-1:0] rptr;
   logic [LW-1:0] count;
   logic          full;
   logic          empty;
   logic          push;
   logic          pop;

   // ##########################################################################
   // flags and handshakes
   // ##########################################################################

   assign full  = (count == LW'(DEPTH));
   assign empty = (count == '0);

   // a pop in the same cycle frees the slot a full fifo needs
   assign wr.ready = ~full | rd.ready;
   assign push     = wr.valid & wr.ready;

   assign rd.valid   = ~empty;
   assign rd.payload = mem[rptr];
   assign pop        = rd.valid & rd.ready;

   assign wr.level = count;

   // ##########################################################################
   // storage
   // ##########################################################################

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wptr] <= wr.payload;
      end
   end

   // pointers wrap on their own since DEPTH is a power of two
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wptr <= '0;
         rptr <= '0;
      end else begin
         if (push) begin
            wptr <= wptr + 1'b1;
         end
         if (pop) begin
            rptr <= rptr + 1'b1;
         end
      end
   end

   // occupancy, unchanged on push with pop
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         count <= '0;
      end else begin
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- src/par2ser.sv
// parallel to serial shifter sending SW bits per beat with a beat counter and serial wait
`default_nettype none
`timescale 1ns/1ps

module par2ser
   import ser_pkg::*;
#(
   parameter int PW = 32,
   parameter int SW = 2
) (
   input  wire           clk,
   input  wire           nreset,
   input  wire           ser_wait,
   // words from the fifo head
   ser_word_if.consumer  word_out,
   // serial side
   output logic [SW-1:0] dout,
   output logic          access_out,
   output logic          busy
);

   localparam int BEATS = PW / SW;
   // one bit of headroom so a full word of BEATS fits
   localparam int CW    = $clog2(BEATS) + 1;

   logic [PW-1:0] head_data;
   tx_ctrl_t      head_ctrl;
   logic [PW-1:0] shreg;
   logic [CW-1:0] count;
   logic          lsb_q;
   logic          sent;
   logic          last;
   logic          load;

   assign {head_data, head_ctrl} = word_out.payload;

   // ##########################################################################
   // beat control
   // ##########################################################################

   // beats remain while the counter is nonzero
   assign access_out = (count != '0);
   assign busy       = access_out;

   // a beat leaves on an edge without wait
   assign sent = access_out & ~ser_wait;
   assign last = (count == CW'(1));

   // idle, or finishing the last beat, so words stream back to back
   assign word_out.ready = ~access_out | (last & ~ser_wait);
   assign load           = word_out.valid & word_out.ready;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         count <= '0;
         lsb_q <= 1'b0;
      end else if (load) begin
         count <= CW'(head_ctrl.size);
         lsb_q <= head_ctrl.lsbfirst;
      end else if (sent) begin
         count <= count - 1'b1;
      end
   end

   // ##########################################################################
   // shift register
   // ##########################################################################

   // zeros shift in behind the data
   always_ff @(posedge clk) begin
      if (load) begin
         shreg <= head_data;
      end else if (sent && lsb_q) begin
         shreg <= {{SW{1'b0}}, shreg[PW-1:SW]};
      end else if (sent) begin
         shreg <= {shreg[PW-SW-1:0], {SW{1'b0}}};
      end
   end

   // bottom bits for lsb first, top bits otherwise
   assign dout = lsb_q ? shreg[SW-1:0] : shreg[PW-1:PW-SW];

endmodule

`default_nettype wire

//--- src/serial_tx_top.sv
// APB programmed serial transmitter top with register block, word FIFO and serializer
`default_nettype none
`timescale 1ns/1ps

module serial_tx_top
   import ser_pkg::*;
#(
   parameter int PW    = 32,
   parameter int SW    = 2,
   parameter int DEPTH = 4
) (
   input  wire              clk,
   input  wire              nreset,
   // apb slave
   input  wire [ADDR_W-1:0] paddr,
   input  wire              psel,
   input  wire              penable,
   input  wire              pwrite,
   input  wire [31:0]       pwdata,
   output logic [31:0]      prdata,
   output logic             pready,
   output logic             pslverr,
   // serial output
   output logic [SW-1:0]    dout,
   output logic             access_out,
   input  wire              ser_wait
);

   // queued word, data above its control
   typedef struct packed {
      logic [PW-1:0] data;
      tx_ctrl_t      ctrl;
   } tx_word_t;

   logic tx_busy;

   // register block to fifo, fifo to shifter
   ser_word_if #(.payload_t(tx_word_t), .DEPTH(DEPTH)) word_in ();
   ser_word_if #(.payload_t(tx_word_t), .DEPTH(DEPTH)) word_out ();

   apb_tx_regs #(.PW(PW), .SW(SW)) regs0 (
      .clk     (clk),
      .nreset  (nreset),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .word_in (word_in.producer),
      .busy    (tx_busy)
   );

   tx_fifo #(.payload_t(tx_word_t), .DEPTH(DEPTH)) fifo0 (
      .clk    (clk),
      .nreset (nreset),
      .wr     (word_in.consumer),
      .rd     (word_out.producer)
   );

   par2ser #(.PW(PW), .SW(SW)) ser0 (
      .clk        (clk),
      .nreset     (nreset),
      .ser_wait   (ser_wait),
      .word_out   (word_out.consumer),
      .dout       (dout),
      .access_out (access_out),
      .busy       (tx_busy)
   );

endmodule

`default_nettype wire

//--- sim/serial_tx_properties.sv
// serial transmitter assertions on the APB ready rule, beat hold under wait and reset state
`default_nettype none
`timescale 1ns/1ps

module serial_tx_properties #(
   parameter int SW = 2
) (
   input wire          clk,
   input wire          nreset,
   input wire          pready,
   input wire [SW-1:0] dout,
   input wire          access_out,
   input wire          ser_wait
);

   // zero-wait slave
   ap_pready_high: assert property (@(posedge clk) disable iff (!nreset) pready)
      else $error("pready went low");

   // a waited beat keeps its value into the next cycle
   ap_beat_hold: assert property (@(posedge clk) disable iff (!nreset)
      access_out && ser_wait |=> $stable(dout))
      else $error("dout changed while ser_wait held the beat");

   // no serial activity while reset is applied
   ap_reset_idle: assert property (@(posedge clk) !nreset |-> !access_out)
      else $error("access_out high during reset");

endmodule

// the top level carries both the APB pins and the serial pins
bind serial_tx_top serial_tx_properties #(.SW(SW)) props0 (
   .clk(clk), .nreset(nreset), .pready(pready),
   .dout(dout), .access_out(access_out), .ser_wait(ser_wait)
);

`default_nettype wire

//--- sim/serial_tx_tb.sv
// directed testbench for the APB serial transmitter with a serial monitor and stream model
`default_nettype none
`timescale 1ns/1ps

module serial_tx_tb import ser_pkg::*; ();

   localparam int PW    = 32;
   localparam int SW    = 2;
   localparam int DEPTH = 4;
   localparam int BEATS = PW / SW;
   // reset 10, reads 6, short tests about 55, overflow about 105, random burst about 120
   localparam int TEST_CYCLES = 300;
   localparam int TIMEOUT     = 2 * TEST_CYCLES;

   logic              clk;
   logic              nreset;
   logic [ADDR_W-1:0] paddr;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [31:0]       pwdata;
   logic [31:0]       prdata;
   logic              pready;
   logic              pslverr;
   logic [SW-1:0]     dout;
   logic              access_out;
   logic              ser_wait;

   // bookkeeping
   int            errors;
   int            tests_run;
   int            tests_failed;
   int            cycles;
   logic          wait_random;
   tx_ctrl_t      cur_ctrl;
   logic [SW-1:0] rx_q[$];
   logic [PW-1:0] exp_words[$];
   int            exp_sizes[$];

   serial_tx_top #(.PW(PW), .SW(SW), .DEPTH(DEPTH)) dut0 (
      .clk(clk), .nreset(nreset), .paddr(paddr), .psel(psel), .penable(penable),
      .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr), .dout(dout), .access_out(access_out), .ser_wait(ser_wait)
   );

   // ##########################################################################
   // clock, timeout, serial monitor
   // ##########################################################################

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT) begin
         $display("timeout after %0d cycles, the DUT did not finish", cycles);
         $display("=== FAIL ===");
         $finish;
      end
   end

   // a beat leaves on an edge with access_out high and no wait
   always @(posedge clk) begin
      if (nreset && access_out && !ser_wait) begin
         rx_q.push_back(dout);
      end
   end

   // random stall source for the burst test
   always @(negedge clk) begin
      if (wait_random) begin
         ser_wait = 1'($urandom % 2);
      end
   end

   // ##########################################################################
   // compare tasks
   // ##########################################################################

   task automatic check_word(input string name, input logic [PW-1:0] got, input logic [PW-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_ctrl(input string name, input tx_ctrl_t got, input tx_ctrl_t exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   // ##########################################################################
   // APB transfers and stream model
   // ##########################################################################

   // setup phase, access phase sampled mid-low, then idle
   task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                            output logic err);
      @(negedge clk);
      paddr  = addr;
      pwdata = data;
      pwrite = 1'b1;
      psel   = 1'b1;
      @(negedge clk);
      penable = 1'b1;
      #10 err = pslverr;
      // zero-wait slave, every access completes in one cycle
      check_bit("pready", pready, 1'b1);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
      @(negedge clk);
      paddr  = addr;
      pwrite = 1'b0;
      psel   = 1'b1;
      @(negedge clk);
      penable = 1'b1;
      #10 data = prdata;
      check_bit("pready", pready, 1'b1);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // beats of one word packed in arrival order, first beat highest
   function automatic logic [PW-1:0] model_stream(input logic [PW-1:0] data, input tx_ctrl_t c);
      logic [PW-1:0] acc;
      int            i;
      acc = '0;
      for (i = 0; i < c.size; i++) begin
         if (c.lsbfirst)
            acc = (acc << SW) | PW'(data[i*SW +: SW]);
         else
            acc = (acc << SW) | PW'(data[PW-SW-i*SW +: SW]);
      end
      return acc;
   endfunction

   task automatic set_ctrl(input logic lsb, input logic [7:0] size, input logic exp_err);
      tx_ctrl_t c;
      logic     err;
      c.lsbfirst = lsb;
      c.size     = size;
      apb_write(REG_CTRL, 32'(c), err);
      check_bit("pslverr", err, exp_err);
      if (!exp_err) cur_ctrl = c;
   endtask

   // accepted words join the expected stream with the control in force
   task automatic send_word(input logic [PW-1:0] data, input logic exp_err);
      logic err;
      apb_write(REG_DATA, data, err);
      check_bit("pslverr", err, exp_err);
      if (!exp_err) begin
         exp_words.push_back(model_stream(data, cur_ctrl));
         exp_sizes.push_back(cur_ctrl.size);
      end
   endtask

   task automatic drain_and_compare();
      logic [PW-1:0] acc;
      int            total;
      int            n;
      int            b;
      total = 0;
      foreach (exp_sizes[i]) total += exp_sizes[i];
      while (rx_q.size() < total) @(negedge clk);
      @(negedge clk);
      check_bit("access_out", access_out, 1'b0);
      while (exp_words.size() > 0) begin
         n   = exp_sizes.pop_front();
         acc = '0;
         for (b = 0; b < n; b++) acc = (acc << SW) | PW'(rx_q.pop_front());
         check_word("dout stream", acc, exp_words.pop_front());
      end
      if (rx_q.size() != 0) begin
         errors++;
         $display("%0d beats were sent beyond the expected words", rx_q.size());
         rx_q.delete();
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests_run++;
      if (errors != errors_before) begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, errors - errors_before);
      end else begin
         $display("%s: ok", name);
      end
   endtask

   // ##########################################################################
   // directed tests
   // ##########################################################################

   task automatic reset_values();
      int          e;
      logic [31:0] rd;
      tx_ctrl_t    exp;
      e            = errors;
      exp.lsbfirst = 1'b0;
      exp.size     = 8'(BEATS);
      apb_read(REG_STATUS, rd);
      check_word("status", rd, '0);
      apb_read(REG_CTRL, rd);
      check_ctrl("ctrl", rd[$bits(tx_ctrl_t)-1:0], exp);
      cur_ctrl = exp;
      report_test("reset values", e);
   endtask

   task automatic msb_full_word();
      int e;
      e = errors;
      set_ctrl(1'b0, 8'(BEATS), 1'b0);
      send_word($urandom, 1'b0);
      drain_and_compare();
      report_test("msb first full word", e);
   endtask

   task automatic lsb_short_word();
      int e;
      e = errors;
      set_ctrl(1'b1, 8'd5, 1'b0);
      send_word($urandom, 1'b0);
      drain_and_compare();
      report_test("lsb first short word", e);
   endtask

   task automatic bad_ctrl_refused();
      int          e;
      logic [31:0] rd;
      e = errors;
      set_ctrl(1'b0, 8'd0, 1'b1);
      set_ctrl(1'b0, 8'(BEATS + 1), 1'b1);
      apb_read(REG_CTRL, rd);
      check_ctrl("ctrl", rd[$bits(tx_ctrl_t)-1:0], cur_ctrl);
      report_test("bad ctrl refused", e);
   endtask

   task automatic fifo_overflow();
      int          e;
      logic [31:0] rd;
      e = errors;
      set_ctrl(1'b0, 8'(BEATS), 1'b0);
      @(negedge clk);
      ser_wait = 1'b1;
      // the first word moves on into the shifter
      repeat (DEPTH + 1) send_word($urandom, 1'b0);
      send_word($urandom, 1'b1);
      apb_read(REG_STATUS, rd);
      check_word("status", rd, (32'(DEPTH) << STAT_LEVEL_LSB) | 32'h3);
      @(negedge clk);
      ser_wait = 1'b0;
      drain_and_compare();
      report_test("fifo overflow", e);
   endtask

   task automatic wait_toggle_burst();
      int e;
      e           = errors;
      wait_random = 1'b1;
      set_ctrl(1'b0, 8'(BEATS), 1'b0);
      send_word($urandom, 1'b0);
      send_word($urandom, 1'b0);
      set_ctrl(1'b1, 8'd9, 1'b0);
      send_word($urandom, 1'b0);
      send_word($urandom, 1'b0);
      drain_and_compare();
      @(negedge clk);
      wait_random = 1'b0;
      ser_wait    = 1'b0;
      report_test("random wait burst", e);
   endtask

   // ##########################################################################
   // main sequence
   // ##########################################################################

   initial begin
      void'($urandom(27));
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      cycles       = 0;
      wait_random  = 1'b0;
      nreset       = 1'b0;
      paddr        = '0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      pwdata       = '0;
      ser_wait     = 1'b0;
      repeat (10) @(negedge clk);
      nreset = 1'b1;

      reset_values();
      msb_full_word();
      lsb_short_word();
      bad_ctrl_refused();
      fifo_overflow();
      wait_toggle_burst();

      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
src/ser_pkg.sv
src/ser_word_if.sv
src/apb_tx_regs.sv
src/tx_fifo.sv
src/par2ser.sv
src/serial_tx_top.sv
sim/serial_tx_properties.sv
sim/serial_tx_tb.sv
